/* include/openriscv_defs.svh */
`ifndef OPENRISCV_DEFS_SVH
`define OPENRISCV_DEFS_SVH

// data and address width
`define XLEN        32

// register index width
`define REG_ADDR_W  5

// first fetch address after reset
`define RESET_PC    32'h0000_0000

// addi x0, x0, 0
`define NOP_INST    32'h0000_0013

// one bit each for pc, if_id, id_ex, ex_ls, ls_wb
`define STALL_W     5

`endif

/* openriscv.f */
+incdir+include
verilog/openriscv_pkg.sv
verilog/ifu.sv
verilog/stage_reg.sv
verilog/idu.sv
verilog/exu.sv
verilog/lsu.sv
verilog/regfile.sv
verilog/openriscv.sv
testbench/openriscv_checker.sv
testbench/openriscv_tb.sv

/* testbench/openriscv_checker.sv */
`timescale 1ns/1ps
`include "openriscv_defs.svh"

module openriscv_checker (
    input logic             clk,
    input logic             arst_n_i,
    input logic             ram_re_i,
    input logic [`XLEN-1:0] ram_raddr_i,
    input logic             ram_we_i,
    input logic [`XLEN-1:0] ram_waddr_i
);

    // one memory operation per instruction
    assert property (@(posedge clk) disable iff (!arst_n_i) !(ram_we_i && ram_re_i))
        else $error("ram_we and ram_re high in the same cycle");

    assert property (@(posedge clk) disable iff (!arst_n_i) ram_we_i |-> ram_waddr_i[1:0] == 2'b00)
        else $error("store address %h not word aligned", ram_waddr_i);

    assert property (@(posedge clk) disable iff (!arst_n_i) ram_re_i |-> ram_raddr_i[1:0] == 2'b00)
        else $error("load address %h not word aligned", ram_raddr_i);

    // pipeline holds bubbles in reset
    assert property (@(posedge clk) !arst_n_i |-> !ram_we_i && !ram_re_i)
        else $error("memory strobe high during reset");

endmodule

/* testbench/openriscv_tb.sv */
`timescale 1ns/1ps
`include "openriscv_defs.svh"

module openriscv_tb;

    localparam int N_INST     = 200;
    localparam int CLK_PERIOD = 20;
    localparam int TIMEOUT_NS = N_INST * 4 * CLK_PERIOD + 50 * CLK_PERIOD;
    localparam int LAST_RAND  = N_INST - 4;
    localparam logic [31:0] MARKER_ADDR = 32'd1020;
    localparam logic [31:0] MARKER_DATA = 32'hc0de_d000;

    typedef enum int {
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT,
        K_ADDI, K_LUI, K_LW, K_SW, K_JAL, K_BEQ, K_BNE
    } kind_e;

    logic        clk;
    logic        arst_n_i;
    logic [31:0] rom_inst_i;
    logic [31:0] rom_pc_o;
    logic [31:0] ram_data_i;
    logic        ram_re_o;
    logic [31:0] ram_raddr_o;
    logic [31:0] ram_data_o;
    logic        ram_we_o;
    logic [31:0] ram_waddr_o;

    kind_e       p_kind [0:N_INST-1];
    logic [4:0]  p_rd   [0:N_INST-1];
    logic [4:0]  p_rs1  [0:N_INST-1];
    logic [4:0]  p_rs2  [0:N_INST-1];
    logic [31:0] p_imm  [0:N_INST-1];
    logic [31:0] rom    [0:255];
    logic [31:0] ram    [0:255];
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];
    logic [31:0] exp_load_q [$];

    integer seed = 59019;
    int     errors = 0;
    int     checks = 0;
    int     n_stores = 0;
    int     n_loads = 0;
    bit     done = 1'b0;

    openriscv i_openriscv (
        .clk(clk), .arst_n_i(arst_n_i), .rom_inst_i(rom_inst_i), .rom_pc_o(rom_pc_o),
        .ram_data_i(ram_data_i), .ram_re_o(ram_re_o), .ram_raddr_o(ram_raddr_o),
        .ram_data_o(ram_data_o), .ram_we_o(ram_we_o), .ram_waddr_o(ram_waddr_o)
    );

    bind openriscv openriscv_checker u_checker (
        .clk(clk), .arst_n_i(arst_n_i), .ram_re_i(ram_re_o), .ram_raddr_i(ram_raddr_o),
        .ram_we_i(ram_we_o), .ram_waddr_i(ram_waddr_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // combinational rom and ram reads
    assign rom_inst_i = rom[rom_pc_o[9:2]];
    assign ram_data_i = ram[ram_raddr_o[9:2]];

    always @(posedge clk) begin
        if (ram_we_o) begin
            ram[ram_waddr_o[9:2]] <= ram_data_o;
        end
    end

    function automatic logic [31:0] fill_word(input int idx);
        logic [31:0] value;
        value = idx * 32'h9e37_79b1;
        return value ^ 32'h0f0f_0f0f;
    endfunction

    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    // half the time reuse the last destination
    function automatic logic [4:0] pick_src(input logic [4:0] recent);
        if (rand_below(2) == 0) begin
            return recent;
        end
        return 5'(rand_below(8));
    endfunction

    function automatic logic [31:0] rand_imm12();
        logic [11:0] v;
        v = 12'(rand_below(4096));
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] encode(input kind_e k, input logic [4:0] rd, rs1, rs2,
                                           input logic [31:0] imm);
        case (k)
            K_ADD:   return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_SUB:   return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_AND:   return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            K_OR:    return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            K_XOR:   return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            K_SLT:   return {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
            K_ADDI:  return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            K_LUI:   return {imm[31:12], rd, 7'b0110111};
            K_LW:    return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
            K_SW:    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
            K_JAL:   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            K_BEQ:   return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
            default: return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
        endcase
    endfunction

    task automatic set_inst(input int i, input kind_e k, input logic [4:0] rd, rs1, rs2,
                            input logic [31:0] imm);
        p_kind[i] = k;
        p_rd[i]   = rd;
        p_rs1[i]  = rs1;
        p_rs2[i]  = rs2;
        p_imm[i]  = imm;
    endtask

    task automatic gen_program();
        int         r;
        int         tgt;
        kind_e      k;
        logic [4:0] rd;
        logic [4:0] last_rd;
        // x1..x7 get full 32-bit values first
        for (int n = 1; n < 8; n++) begin
            set_inst(2 * n - 2, K_LUI, 5'(n), 5'd0, 5'd0, {20'(rand_below(1 << 20)), 12'b0});
            set_inst(2 * n - 1, K_ADDI, 5'(n), 5'(n), 5'd0, rand_imm12());
        end
        last_rd = 5'd7;
        for (int i = 14; i <= LAST_RAND; i++) begin
            r   = rand_below(100);
            rd  = 5'(rand_below(8));
            // targets never pass the marker sequence
            tgt = i + 1 + rand_below(6);
            if (tgt > LAST_RAND + 1) begin
                tgt = LAST_RAND + 1;
            end
            if (r < 30) begin
                k = kind_e'(rand_below(6));
                set_inst(i, k, rd, pick_src(last_rd), pick_src(last_rd), '0);
            end else if (r < 42) begin
                set_inst(i, K_ADDI, rd, pick_src(last_rd), 5'd0, rand_imm12());
            end else if (r < 48) begin
                set_inst(i, K_LUI, rd, 5'd0, 5'd0, {20'(rand_below(1 << 20)), 12'b0});
            end else if (r < 63) begin
                set_inst(i, K_LW, rd, 5'd0, 5'd0, 32'(rand_below(32) * 4));
            end else if (r < 80) begin
                set_inst(i, K_SW, 5'd0, 5'd0, pick_src(last_rd), 32'(rand_below(32) * 4));
            end else if (r < 86) begin
                set_inst(i, K_JAL, rd, 5'd0, 5'd0, 32'((tgt - i) * 4));
            end else begin
                k = (rand_below(2) == 0) ? K_BEQ : K_BNE;
                set_inst(i, k, 5'd0, pick_src(last_rd), pick_src(last_rd), 32'((tgt - i) * 4));
                // equal operands now and then so BEQ gets taken
                if (rand_below(4) == 0) begin
                    p_rs2[i] = p_rs1[i];
                end
            end
            if (!(p_kind[i] inside {K_SW, K_BEQ, K_BNE}) && rd != 5'd0) begin
                last_rd = rd;
            end
        end
        set_inst(N_INST - 3, K_LUI, 5'd31, 5'd0, 5'd0, MARKER_DATA);
        set_inst(N_INST - 2, K_SW, 5'd0, 5'd0, 5'd31, MARKER_ADDR);
        set_inst(N_INST - 1, K_JAL, 5'd0, 5'd0, 5'd0, 32'd0);
        for (int i = 0; i < 256; i++) begin
            rom[i] = (i < N_INST) ? encode(p_kind[i], p_rd[i], p_rs1[i], p_rs2[i], p_imm[i])
                                  : `NOP_INST;
            ram[i] = fill_word(i);
        end
    endtask

    // ISA level interpreter that records every store and load in order
    task automatic run_model();
        logic [31:0] regs [0:31];
        logic [31:0] mem  [0:255];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        int          pc;
        int          steps;
        for (int n = 0; n < 32; n++) begin
            regs[n] = '0;
        end
        for (int n = 0; n < 256; n++) begin
            mem[n] = fill_word(n);
        end
        pc    = 0;
        steps = 0;
        while (pc != N_INST - 1 && steps < 4 * N_INST) begin
            a    = regs[p_rs1[pc]];
            b    = regs[p_rs2[pc]];
            addr = a + p_imm[pc];
            case (p_kind[pc])
                K_ADD:   res = a + b;
                K_SUB:   res = a - b;
                K_AND:   res = a & b;
                K_OR:    res = a | b;
                K_XOR:   res = a ^ b;
                K_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                K_ADDI:  res = a + p_imm[pc];
                K_LUI:   res = p_imm[pc];
                K_LW:    res = mem[addr[9:2]];
                K_JAL:   res = 32'((pc + 1) * 4);
                default: res = '0;
            endcase
            if (p_kind[pc] == K_LW) begin
                exp_load_q.push_back(addr);
            end
            if (p_kind[pc] == K_SW) begin
                mem[addr[9:2]] = b;
                exp_addr_q.push_back(addr);
                exp_data_q.push_back(b);
            end else if (!(p_kind[pc] inside {K_BEQ, K_BNE}) && p_rd[pc] != 5'd0) begin
                regs[p_rd[pc]] = res;
            end
            if (p_kind[pc] == K_JAL || (p_kind[pc] == K_BEQ && a == b) ||
                (p_kind[pc] == K_BNE && a != b)) begin
                pc = pc + int'(p_imm[pc]) / 4;
            end else begin
                pc = pc + 1;
            end
            steps++;
        end
    endtask

    always @(negedge clk) begin
        if (arst_n_i && ram_re_o) begin
            if (n_loads >= exp_load_q.size()) begin
                errors++;
                $display("ERROR: unexpected extra load from %h", ram_raddr_o);
            end else begin
                checks++;
                if (ram_raddr_o !== exp_load_q[n_loads]) begin
                    errors++;
                    $display("FAIL load: expected addr %h, actual addr %h",
                             exp_load_q[n_loads], ram_raddr_o);
                end
            end
            n_loads++;
        end
        if (arst_n_i && ram_we_o) begin
            if (n_stores >= exp_addr_q.size()) begin
                errors++;
                $display("ERROR: unexpected extra store to %h with data %h", ram_waddr_o, ram_data_o);
            end else begin
                checks++;
                if (ram_waddr_o !== exp_addr_q[n_stores] || ram_data_o !== exp_data_q[n_stores]) begin
                    errors++;
                    $display("FAIL store: expected addr %h data %h, actual addr %h data %h",
                             exp_addr_q[n_stores], exp_data_q[n_stores], ram_waddr_o, ram_data_o);
                end
            end
            n_stores++;
            if (ram_waddr_o == MARKER_ADDR) begin
                checks++;
                if (n_stores != exp_addr_q.size()) begin
                    errors++;
                    $display("FAIL count: expected %0d, actual %0d", exp_addr_q.size(), n_stores);
                end
                done = 1'b1;
            end
        end
    end

    initial begin
        clk      = 1'b0;
        arst_n_i = 1'b1;
        gen_program();
        run_model();
        #1;
        arst_n_i = 1'b0;
        #1;
        checks++;
        if (ram_we_o !== 1'b0 || ram_re_o !== 1'b0) begin
            errors++;
            $display("FAIL reset: expected we/re 0/0, actual %b/%b", ram_we_o, ram_re_o);
        end
        checks++;
        if (rom_pc_o !== `RESET_PC) begin
            errors++;
            $display("FAIL reset: expected pc %h, actual %h", `RESET_PC, rom_pc_o);
        end
        repeat (5) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        wait (done);
        repeat (2) @(posedge clk);
        $display("checks: %0d, stores: %0d, errors: %0d", checks, n_stores, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        errors++;
        $display("ERROR: end marker store never arrived within %0d ns", TIMEOUT_NS);
        $display("checks: %0d, stores: %0d, errors: %0d", checks, n_stores, errors);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* verilog/exu.sv */
`timescale 1ns/1ps
`include "openriscv_defs.svh"

module exu (
    input  openriscv_pkg::id_ex_t dec_i,
    output openriscv_pkg::ex_ls_t res_o,
    output openriscv_pkg::wb_t    fwd_o,
    output logic                  is_load_o
);

    logic [`XLEN-1:0] alu_res;

    always_comb begin
        case (dec_i.alu_op)
            openriscv_pkg::ALU_ADD:  alu_res = dec_i.op1 + dec_i.op2;
            openriscv_pkg::ALU_SUB:  alu_res = dec_i.op1 - dec_i.op2;
            openriscv_pkg::ALU_AND:  alu_res = dec_i.op1 & dec_i.op2;
            openriscv_pkg::ALU_OR:   alu_res = dec_i.op1 | dec_i.op2;
            openriscv_pkg::ALU_XOR:  alu_res = dec_i.op1 ^ dec_i.op2;
            openriscv_pkg::ALU_SLT: begin
                alu_res = {{(`XLEN-1){1'b0}}, $signed(dec_i.op1) < $signed(dec_i.op2)};
            end
            openriscv_pkg::ALU_PASS: alu_res = dec_i.op2;
            default:                 alu_res = '0;
        endcase
    end

    // loads and stores decode as add, so alu_res is the address
    always_comb begin
        res_o.rd_we    = dec_i.rd_we;
        res_o.rd_addr  = dec_i.rd_addr;
        res_o.mem_addr = alu_res;
        res_o.mem_op   = dec_i.mem_op;
        res_o.result   = (dec_i.mem_op == openriscv_pkg::MEM_STORE) ? dec_i.store_data
                                                                    : alu_res;
    end

    always_comb begin
        fwd_o.we   = dec_i.rd_we;
        fwd_o.addr = dec_i.rd_addr;
        fwd_o.data = alu_res;
    end

    assign is_load_o = (dec_i.mem_op == openriscv_pkg::MEM_LOAD);

endmodule

/* verilog/idu.sv */
`timescale 1ns/1ps
`include "openriscv_defs.svh"

module idu (
    input  openriscv_pkg::if_id_t   fetch_i,
    output logic [`REG_ADDR_W-1:0]  rs1_addr_o,
    output logic [`REG_ADDR_W-1:0]  rs2_addr_o,
    output logic                    rs1_re_o,
    output logic                    rs2_re_o,
    input  logic [`XLEN-1:0]        rs1_data_i,
    input  logic [`XLEN-1:0]        rs2_data_i,
    input  openriscv_pkg::wb_t      ex_fwd_i,
    input  openriscv_pkg::wb_t      ls_fwd_i,
    input  logic                    ex_is_load_i,
    output openriscv_pkg::id_ex_t   dec_o,
    output logic [`STALL_W-1:0]     stall_o,
    output logic                    jump_req_o,
    output logic [`XLEN-1:0]        jump_pc_o
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    logic [31:0]      inst;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    logic             is_jal;
    logic             is_beq;
    logic             is_bne;
    logic             load_use;

    assign inst       = fetch_i.inst;
    assign opcode     = inst[6:0];
    assign funct3     = inst[14:12];
    assign rs1_addr_o = inst[19:15];
    assign rs2_addr_o = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // exu result first, then lsu, then the register file
    function automatic logic [`XLEN-1:0] fwd(input logic [`REG_ADDR_W-1:0] addr,
                                            input logic [`XLEN-1:0] rf_data,
                                            input openriscv_pkg::wb_t ex,
                                            input openriscv_pkg::wb_t ls);
        if (addr != '0 && ex.we && ex.addr == addr) begin
            return ex.data;
        end else if (addr != '0 && ls.we && ls.addr == addr) begin
            return ls.data;
        end
        return rf_data;
    endfunction

    assign op1 = fwd(rs1_addr_o, rs1_data_i, ex_fwd_i, ls_fwd_i);
    assign op2 = fwd(rs2_addr_o, rs2_data_i, ex_fwd_i, ls_fwd_i);

    // read enables depend on the opcode alone
    always_comb begin
        rs1_re_o = opcode inside {OPC_OP, OPC_OPIMM, OPC_LOAD, OPC_STORE, OPC_BRANCH};
        rs2_re_o = opcode inside {OPC_OP, OPC_STORE, OPC_BRANCH};
    end

    always_comb begin
        dec_o            = '0;
        dec_o.pc         = fetch_i.pc;
        dec_o.op1        = op1;
        dec_o.op2        = op2;
        dec_o.store_data = op2;
        dec_o.rd_addr    = inst[11:7];
        is_jal           = 1'b0;
        is_beq           = 1'b0;
        is_bne           = 1'b0;
        case (opcode)
            OPC_OP: begin
                dec_o.rd_we = 1'b1;
                case (funct3)
                    3'b000:  dec_o.alu_op = inst[30] ? openriscv_pkg::ALU_SUB
                                                     : openriscv_pkg::ALU_ADD;
                    3'b111:  dec_o.alu_op = openriscv_pkg::ALU_AND;
                    3'b110:  dec_o.alu_op = openriscv_pkg::ALU_OR;
                    3'b100:  dec_o.alu_op = openriscv_pkg::ALU_XOR;
                    3'b010:  dec_o.alu_op = openriscv_pkg::ALU_SLT;
                    default: dec_o.rd_we = 1'b0;
                endcase
            end
            OPC_OPIMM: begin
                dec_o.rd_we = (funct3 == 3'b000);
                dec_o.op2   = imm_i;
            end
            OPC_LUI: begin
                dec_o.rd_we  = 1'b1;
                dec_o.op2    = imm_u;
                dec_o.alu_op = openriscv_pkg::ALU_PASS;
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    dec_o.rd_we  = 1'b1;
                    dec_o.mem_op = openriscv_pkg::MEM_LOAD;
                end
                dec_o.op2 = imm_i;
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    dec_o.mem_op = openriscv_pkg::MEM_STORE;
                end
                dec_o.op2 = imm_s;
            end
            OPC_JAL: begin
                // link address goes through the adder as pc + 4
                is_jal      = 1'b1;
                dec_o.rd_we = 1'b1;
                dec_o.op1   = fetch_i.pc;
                dec_o.op2   = 'd4;
            end
            OPC_BRANCH: begin
                is_beq = (funct3 == 3'b000);
                is_bne = (funct3 == 3'b001);
            end
            default: ;
        endcase
    end

    // a load in execute cannot forward yet
    assign load_use = ex_is_load_i && ex_fwd_i.we && ex_fwd_i.addr != '0 &&
                      ((rs1_re_o && ex_fwd_i.addr == rs1_addr_o) ||
                       (rs2_re_o && ex_fwd_i.addr == rs2_addr_o));

    assign stall_o = {2'b00, {3{load_use}}};

    assign jump_req_o = !load_use && (is_jal || (is_beq && op1 == op2) ||
                                      (is_bne && op1 != op2));
    assign jump_pc_o  = fetch_i.pc + (is_jal ? imm_j : imm_b);

endmodule

/* verilog/ifu.sv */
`timescale 1ns/1ps
`include "openriscv_defs.svh"

module ifu (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic [`XLEN-1:0]      inst_i,
    input  logic [`STALL_W-1:0]   stall_i,
    input  logic                  jump_req_i,
    input  logic [`XLEN-1:0]      jump_pc_i,
    output logic [`XLEN-1:0]      pc_o,
    output openriscv_pkg::if_id_t fetch_o
);

    logic [`XLEN-1:0] pc;

    // a jump wins over a held pc
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc <= `RESET_PC;
        end else if (jump_req_i) begin
            pc <= jump_pc_i;
        end else if (!stall_i[0]) begin
            pc <= pc + 'd4;
        end
    end

    assign pc_o = pc;

    // squash the fall-through instruction of a taken jump
    always_comb begin
        fetch_o.pc   = pc;
        fetch_o.inst = jump_req_i ? `NOP_INST : inst_i;
    end

endmodule

/* verilog/lsu.sv */
`timescale 1ns/1ps
`include "openriscv_defs.svh"

module lsu (
    input  openriscv_pkg::ex_ls_t res_i,
    input  logic [`XLEN-1:0]      ram_data_i,
    output logic                  ram_re_o,
    output logic [`XLEN-1:0]      ram_raddr_o,
    output logic [`XLEN-1:0]      ram_data_o,
    output logic                  ram_we_o,
    output logic [`XLEN-1:0]      ram_waddr_o,
    output openriscv_pkg::wb_t    wb_o
);

    logic is_load;

    assign is_load = (res_i.mem_op == openriscv_pkg::MEM_LOAD);

    // strobes come straight from mem_op, a bubble keeps both low
    assign ram_re_o    = is_load;
    assign ram_raddr_o = res_i.mem_addr;
    assign ram_we_o    = (res_i.mem_op == openriscv_pkg::MEM_STORE);
    assign ram_waddr_o = res_i.mem_addr;
    assign ram_data_o  = res_i.result;

    // also the forwarding bus into decode
    always_comb begin
        wb_o.we   = res_i.rd_we;
        wb_o.addr = res_i.rd_addr;
        wb_o.data = is_load ? ram_data_i : res_i.result;
    end

endmodule

/* verilog/openriscv.sv */
`timescale 1ns/1ps
`include "openriscv_defs.svh"

module openriscv (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic [`XLEN-1:0]   rom_inst_i,
    output logic [`XLEN-1:0]   rom_pc_o,
    input  logic [`XLEN-1:0]   ram_data_i,
    output logic               ram_re_o,
    output logic [`XLEN-1:0]   ram_raddr_o,
    output logic [`XLEN-1:0]   ram_data_o,
    output logic               ram_we_o,
    output logic [`XLEN-1:0]   ram_waddr_o
);

    logic [`STALL_W-1:0]    stall;
    logic                   jump_req;
    logic [`XLEN-1:0]       jump_pc;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`REG_ADDR_W-1:0] rs2_addr;
    logic                   rs1_re;
    logic                   rs2_re;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic                   ex_is_load;
    openriscv_pkg::if_id_t  if_fetch;
    openriscv_pkg::if_id_t  id_fetch;
    openriscv_pkg::id_ex_t  id_dec;
    openriscv_pkg::id_ex_t  ex_dec;
    openriscv_pkg::ex_ls_t  ex_res;
    openriscv_pkg::ex_ls_t  ls_res;
    openriscv_pkg::wb_t     ex_fwd;
    openriscv_pkg::wb_t     ls_wb;
    openriscv_pkg::wb_t     wb_wr;

    ifu u_ifu (
        .clk(clk), .arst_n_i(arst_n_i), .inst_i(rom_inst_i), .stall_i(stall),
        .jump_req_i(jump_req), .jump_pc_i(jump_pc), .pc_o(rom_pc_o), .fetch_o(if_fetch)
    );

    stage_reg #(.payload_t(openriscv_pkg::if_id_t), .STAGE(1)) u_if_id (
        .clk(clk), .arst_n_i(arst_n_i), .stall_i(stall), .d_i(if_fetch), .q_o(id_fetch)
    );

    idu u_idu (
        .fetch_i(id_fetch),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_re_o(rs1_re), .rs2_re_o(rs2_re),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .ex_fwd_i(ex_fwd), .ls_fwd_i(ls_wb), .ex_is_load_i(ex_is_load),
        .dec_o(id_dec), .stall_o(stall), .jump_req_o(jump_req), .jump_pc_o(jump_pc)
    );

    stage_reg #(.payload_t(openriscv_pkg::id_ex_t), .STAGE(2)) u_id_ex (
        .clk(clk), .arst_n_i(arst_n_i), .stall_i(stall), .d_i(id_dec), .q_o(ex_dec)
    );

    exu u_exu (
        .dec_i(ex_dec), .res_o(ex_res), .fwd_o(ex_fwd), .is_load_o(ex_is_load)
    );

    stage_reg #(.payload_t(openriscv_pkg::ex_ls_t), .STAGE(3)) u_ex_ls (
        .clk(clk), .arst_n_i(arst_n_i), .stall_i(stall), .d_i(ex_res), .q_o(ls_res)
    );

    lsu u_lsu (
        .res_i(ls_res), .ram_data_i(ram_data_i),
        .ram_re_o(ram_re_o), .ram_raddr_o(ram_raddr_o), .ram_data_o(ram_data_o),
        .ram_we_o(ram_we_o), .ram_waddr_o(ram_waddr_o), .wb_o(ls_wb)
    );

    stage_reg #(.payload_t(openriscv_pkg::wb_t), .STAGE(4)) u_ls_wb (
        .clk(clk), .arst_n_i(arst_n_i), .stall_i(stall), .d_i(ls_wb), .q_o(wb_wr)
    );

    regfile u_regfile (
        .clk(clk),
        .raddr1_i(rs1_addr), .raddr2_i(rs2_addr), .re1_i(rs1_re), .re2_i(rs2_re),
        .rdata1_o(rs1_data), .rdata2_o(rs2_data), .wb_i(wb_wr)
    );

endmodule

/* verilog/openriscv_pkg.sv */
`include "openriscv_defs.svh"

package openriscv_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_PASS = 4'd6
    } alu_op_e;

    // zero encoding is a bubble
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      inst;
    } if_id_t;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       op1;
        logic [`XLEN-1:0]       op2;
        logic [`XLEN-1:0]       store_data;
        logic [`REG_ADDR_W-1:0] rd_addr;
        logic                   rd_we;
        alu_op_e                alu_op;
        mem_op_e                mem_op;
    } id_ex_t;

    typedef struct packed {
        logic                   rd_we;
        logic [`REG_ADDR_W-1:0] rd_addr;
        logic [`XLEN-1:0]       result;
        logic [`XLEN-1:0]       mem_addr;
        mem_op_e                mem_op;
    } ex_ls_t;

    typedef struct packed {
        logic                   we;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
    } wb_t;

endpackage

/* verilog/regfile.sv */
`timescale 1ns/1ps
`include "openriscv_defs.svh"

module regfile (
    input  logic                   clk,
    input  logic [`REG_ADDR_W-1:0] raddr1_i,
    input  logic [`REG_ADDR_W-1:0] raddr2_i,
    input  logic                   re1_i,
    input  logic                   re2_i,
    output logic [`XLEN-1:0]       rdata1_o,
    output logic [`XLEN-1:0]       rdata2_o,
    input  openriscv_pkg::wb_t     wb_i
);

    logic [`XLEN-1:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (wb_i.we && wb_i.addr != '0) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // write-back bypass, x0 and disabled ports read zero
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr,
                                                  input logic re,
                                                  input logic [`XLEN-1:0] stored,
                                                  input openriscv_pkg::wb_t wb);
        if (!re || addr == '0) begin
            return '0;
        end else if (wb.we && wb.addr == addr) begin
            return wb.data;
        end
        return stored;
    endfunction

    assign rdata1_o = read_port(raddr1_i, re1_i, regs[raddr1_i], wb_i);
    assign rdata2_o = read_port(raddr2_i, re2_i, regs[raddr2_i], wb_i);

endmodule

/* verilog/stage_reg.sv */
`timescale 1ns/1ps
`include "openriscv_defs.svh"

module stage_reg #(
    parameter type payload_t = logic [31:0],
    parameter int  STAGE     = 1
) (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic [`STALL_W-1:0] stall_i,
    input  payload_t            d_i,
    output payload_t            q_o
);

    logic next_stall;
    logic hold;
    logic bubble;

    // last stage has no successor
    generate
        if (STAGE + 1 < `STALL_W) begin : g_next
            assign next_stall = stall_i[STAGE+1];
        end else begin : g_last
            assign next_stall = 1'b0;
        end
    endgenerate

    assign hold   = stall_i[STAGE] & next_stall;
    assign bubble = stall_i[STAGE] & ~next_stall;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;
        end else if (bubble) begin
            q_o <= '0;
        end else if (!hold) begin
            q_o <= d_i;
        end
    end

endmodule
